// ==== logic/conv_pkg.sv ====
package conv_pkg;

    //////////////////////////////
    // Frame geometry
    //////////////////////////////

    // Input frame, one 8-bit pixel per position
    localparam int FRAME_WIDTH  = 31;
    localparam int FRAME_HEIGHT = 31;

    // Square kernel, weights listed row-major
    localparam int KERNEL_SIZE = 5;
    localparam int KERNEL_TAPS = KERNEL_SIZE * KERNEL_SIZE;

    // Output feature maps
    localparam int NUM_FILTERS = 6;

    // Column and line counter widths
    localparam int COL_W  = $clog2(FRAME_WIDTH);
    localparam int LINE_W = $clog2(FRAME_HEIGHT);

    //////////////////////////////
    // Datapath widths
    //////////////////////////////

    localparam int PIXEL_W  = 8;   // unsigned
    localparam int COEFF_W  = 16;  // signed weight or bias
    localparam int PROD_W   = 25;  // signed weight x zero-extended pixel
    localparam int RESULT_W = 32;  // 25 products plus bias, no overflow

    // Adder tree goes 25, 13, 7, 4, 2, 1
    localparam int TREE_LEVELS = 5;
    // Multiply stage, tree stages, bias stage
    localparam int MAC_LATENCY = TREE_LEVELS + 2;

    //////////////////////////////
    // Coefficient map
    //////////////////////////////

    // Per filter: slots 0-24 weights, slot 25 bias, rest unmapped
    localparam int COEFF_SLOTS = 32;
    localparam int BIAS_SLOT   = 25;
    localparam int SLOT_W      = $clog2(COEFF_SLOTS);

    // APB word index is paddr[9:2], filter in the upper bits
    localparam int APB_ADDR_W = 10;
    localparam int APB_DATA_W = 32;
    localparam int FILT_W     = APB_ADDR_W - 2 - SLOT_W;

endpackage

// ==== logic/conv_coeff_regs.sv ====
`timescale 1ns/1ps

module conv_coeff_regs import conv_pkg::*; (
    input  logic                                          i_clk,
    input  logic                                          i_rst,
    input  logic                                          i_psel,
    input  logic                                          i_penable,
    input  logic                                          i_pwrite,
    input  logic [APB_ADDR_W-1:0]                         i_paddr,
    input  logic [APB_DATA_W-1:0]                         i_pwdata,
    output logic                                          o_pready,
    output logic [APB_DATA_W-1:0]                         o_prdata,
    output logic                                          o_pslverr,
    output logic [NUM_FILTERS-1:0][KERNEL_TAPS-1:0][COEFF_W-1:0] o_weights,
    output logic [NUM_FILTERS-1:0][COEFF_W-1:0]           o_biases
);

    // Coefficient storage
    logic [NUM_FILTERS-1:0][KERNEL_TAPS-1:0][COEFF_W-1:0] weight_q;
    logic [NUM_FILTERS-1:0][COEFF_W-1:0]                  bias_q;

    // Address decode
    logic [FILT_W-1:0]  filt;
    logic [SLOT_W-1:0]  slot;
    logic               addr_err;
    logic               access;
    logic [COEFF_W-1:0] rd_coeff;

    //////////////////////////////
    // Decode
    //////////////////////////////

    // Byte address, word aligned
    assign filt = i_paddr[APB_ADDR_W-1 -: FILT_W];
    assign slot = i_paddr[2 +: SLOT_W];

    // Unmapped filter or slot above the bias
    assign addr_err = (filt >= FILT_W'(NUM_FILTERS)) || (slot > SLOT_W'(BIAS_SLOT));

    // Access phase, zero wait states
    assign access    = i_psel && i_penable;
    assign o_pready  = access;
    assign o_pslverr = access && addr_err;

    //////////////////////////////
    // Write path
    //////////////////////////////

    // Commit on the edge that ends the access phase
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            weight_q <= '0;
            bias_q   <= '0;
        end else if (access && i_pwrite && !addr_err) begin
            if (slot == SLOT_W'(BIAS_SLOT)) begin
                bias_q[filt] <= i_pwdata[COEFF_W-1:0];
            end else begin
                weight_q[filt][slot] <= i_pwdata[COEFF_W-1:0];
            end
        end
    end

    //////////////////////////////
    // Read path
    //////////////////////////////

    // Errored reads return zero
    always_comb begin
        rd_coeff = '0;
        if (access && !addr_err) begin
            if (slot == SLOT_W'(BIAS_SLOT)) begin
                rd_coeff = bias_q[filt];
            end else begin
                rd_coeff = weight_q[filt][slot];
            end
        end
    end

    // Sign extend into the bus word
    assign o_prdata = {{(APB_DATA_W-COEFF_W){rd_coeff[COEFF_W-1]}}, rd_coeff};

    // Coefficients straight to the filters
    assign o_weights = weight_q;
    assign o_biases  = bias_q;

endmodule

// ==== logic/conv_line_buffer.sv ====
`timescale 1ns/1ps

module conv_line_buffer import conv_pkg::*; (
    input  logic                                i_clk,
    input  logic                                i_rst,
    input  logic                                i_pix_valid,
    input  logic [PIXEL_W-1:0]                  i_pix,
    output logic                                o_win_valid,
    output logic [KERNEL_TAPS-1:0][PIXEL_W-1:0] o_window
);

    // Stored lines above the current one
    localparam int ROWS = KERNEL_SIZE - 1;

    // Position of the incoming pixel
    logic [COL_W-1:0]  col;
    logic [LINE_W-1:0] line;

    // Row 0 holds the oldest line
    logic [PIXEL_W-1:0] row_mem [ROWS][FRAME_WIDTH];

    // Column entering the window, index 0 is the oldest line
    logic [KERNEL_SIZE-1:0][PIXEL_W-1:0] new_col;

    // Window as [row][column], column 0 leftmost
    logic [KERNEL_SIZE-1:0][KERNEL_SIZE-1:0][PIXEL_W-1:0] window;

    // Whole window lies inside the frame
    logic in_frame;

    //////////////////////////////
    // Position counters
    //////////////////////////////

    // Wrap at frame end so the next frame can follow at once
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            col  <= '0;
            line <= '0;
        end else if (i_pix_valid) begin
            if (col == COL_W'(FRAME_WIDTH-1)) begin
                col <= '0;
                if (line == LINE_W'(FRAME_HEIGHT-1)) begin
                    line <= '0;
                end else begin
                    line <= line + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Line memories
    //////////////////////////////

    // Read the four stored pixels above the current column
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            new_col[r] = row_mem[r][col];
        end
        // Newest line comes straight from the input
        new_col[ROWS] = i_pix;
    end

    // Each column moves up by one line per accepted pixel
    always_ff @(posedge i_clk) begin
        if (i_pix_valid) begin
            for (int r = 0; r < ROWS - 1; r++) begin
                row_mem[r][col] <= row_mem[r+1][col];
            end
            row_mem[ROWS-1][col] <= i_pix;
        end
    end

    //////////////////////////////
    // Sliding window
    //////////////////////////////

    // Shift left, new column on the right
    always_ff @(posedge i_clk) begin
        if (i_pix_valid) begin
            for (int r = 0; r < KERNEL_SIZE; r++) begin
                for (int k = 0; k < KERNEL_SIZE - 1; k++) begin
                    window[r][k] <= window[r][k+1];
                end
                window[r][KERNEL_SIZE-1] <= new_col[r];
            end
        end
    end

    // Accepted pixel is the bottom-right corner of the window
    assign in_frame = (line >= LINE_W'(KERNEL_SIZE-1)) && (col >= COL_W'(KERNEL_SIZE-1));

    // Valid one cycle after the accepting edge
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_win_valid <= 1'b0;
        end else begin
            o_win_valid <= i_pix_valid && in_frame;
        end
    end

    // Tap r*KERNEL_SIZE+k is window[r][k]
    assign o_window = window;

endmodule

// ==== logic/conv_filter_mac.sv ====
`timescale 1ns/1ps

module conv_filter_mac import conv_pkg::*; (
    input  logic                                i_clk,
    input  logic                                i_rst,
    input  logic                                i_win_valid,
    input  logic [KERNEL_TAPS-1:0][PIXEL_W-1:0] i_window,
    input  logic [KERNEL_TAPS-1:0][COEFF_W-1:0] i_weights,
    input  logic signed [COEFF_W-1:0]           i_bias,
    output logic                                o_valid,
    output logic signed [RESULT_W-1:0]          o_result
);

    // Nodes left after a number of pairwise levels
    function automatic int node_count(input int level);
        int n;
        n = KERNEL_TAPS;
        for (int l = 0; l < level; l++) begin
            n = (n + 1) / 2;
        end
        return n;
    endfunction

    // Combinational products
    logic signed [PROD_W-1:0] prod [KERNEL_TAPS];

    // Level 0 holds the registered products, level TREE_LEVELS the sum
    logic signed [RESULT_W-1:0] tree [TREE_LEVELS+1][KERNEL_TAPS];

    // Valid follows the data stages
    logic [MAC_LATENCY-1:0] valid_sr;

    //////////////////////////////
    // Multiply stage
    //////////////////////////////

    // Pixel gets a zero sign bit, so 16 x 9 signed
    always_comb begin
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            prod[t] = $signed(i_weights[t]) * $signed({1'b0, i_window[t]});
        end
    end

    for (genvar t = 0; t < KERNEL_TAPS; t++) begin : g_prod
        always_ff @(posedge i_clk) begin
            tree[0][t] <= prod[t];
        end
    end

    //////////////////////////////
    // Adder tree
    //////////////////////////////

    for (genvar l = 0; l < TREE_LEVELS; l++) begin : g_level
        localparam int N_IN = node_count(l);
        for (genvar j = 0; j < KERNEL_TAPS; j++) begin : g_node
            if (2*j + 1 < N_IN) begin : g_add
                // Pair sum
                always_ff @(posedge i_clk) begin
                    tree[l+1][j] <= tree[l][2*j] + tree[l][2*j+1];
                end
            end else if (2*j < N_IN) begin : g_pass
                // Odd leftover, delayed to stay aligned
                always_ff @(posedge i_clk) begin
                    tree[l+1][j] <= tree[l][2*j];
                end
            end else begin : g_idle
                // Slot not used at this level
                assign tree[l+1][j] = '0;
            end
        end
    end

    //////////////////////////////
    // Bias and valid
    //////////////////////////////

    // Bias sign-extends against the tree sum
    always_ff @(posedge i_clk) begin
        o_result <= tree[TREE_LEVELS][0] + i_bias;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[MAC_LATENCY-2:0], i_win_valid};
        end
    end

    assign o_valid = valid_sr[MAC_LATENCY-1];

endmodule

// ==== logic/conv_top.sv ====
`timescale 1ns/1ps

module conv_top import conv_pkg::*; (
    input  logic                                 i_clk,
    input  logic                                 i_rst,
    // APB slave
    input  logic                                 i_psel,
    input  logic                                 i_penable,
    input  logic                                 i_pwrite,
    input  logic [APB_ADDR_W-1:0]                i_paddr,
    input  logic [APB_DATA_W-1:0]                i_pwdata,
    output logic                                 o_pready,
    output logic [APB_DATA_W-1:0]                o_prdata,
    output logic                                 o_pslverr,
    // Pixel stream
    input  logic                                 i_pix_valid,
    input  logic [PIXEL_W-1:0]                   i_pix,
    // One result per filter
    output logic                                 o_res_valid,
    output logic [NUM_FILTERS-1:0][RESULT_W-1:0] o_results
);

    // Coefficients, sliced per filter below
    logic [NUM_FILTERS-1:0][KERNEL_TAPS-1:0][COEFF_W-1:0] weights;
    logic [NUM_FILTERS-1:0][COEFF_W-1:0]                  biases;

    // Window shared by all filters
    logic                                win_valid;
    logic [KERNEL_TAPS-1:0][PIXEL_W-1:0] window;

    // Per-filter valid, all with the same timing
    logic [NUM_FILTERS-1:0] filt_valid;

    conv_coeff_regs coeff_regs_inst (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_pready  (o_pready),
        .o_prdata  (o_prdata),
        .o_pslverr (o_pslverr),
        .o_weights (weights),
        .o_biases  (biases)
    );

    conv_line_buffer line_buffer_inst (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_win_valid (win_valid),
        .o_window    (window)
    );

    //////////////////////////////
    // Filter array
    //////////////////////////////

    for (genvar f = 0; f < NUM_FILTERS; f++) begin : g_filter
        conv_filter_mac filter_mac_inst (
            .i_clk       (i_clk),
            .i_rst       (i_rst),
            .i_win_valid (win_valid),
            .i_window    (window),
            .i_weights   (weights[f]),
            .i_bias      (biases[f]),
            .o_valid     (filt_valid[f]),
            .o_result    (o_results[f])
        );
    end

    // Filter 0 speaks for the whole array
    assign o_res_valid = filt_valid[0];

endmodule

// ==== tb/conv_clk_gen.sv ====
`timescale 1ns/1ps

module conv_clk_gen (
    output logic o_clk,
    output logic o_rst
);

    // 20 ns period, first rising edge at 10 ns
    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

    // Reset held for 10 rising edges, released on the last one
    initial begin
        o_rst = 1'b1;
        repeat (10) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

// ==== tb/conv_assertions.sv ====
`timescale 1ns/1ps

module conv_assertions import conv_pkg::*; (
    input logic                  i_clk,
    input logic                  i_rst,
    input logic                  i_psel,
    input logic                  i_penable,
    input logic [APB_ADDR_W-1:0] i_paddr,
    input logic                  i_pslverr,
    input logic                  i_win_valid,
    input logic                  i_res_valid
);

    // Failure count, read by the testbench at the end of the run
    int assert_fails = 0;

    // Word index is filter times the slot count plus slot
    logic [APB_ADDR_W-3:0] word;
    logic                  unmapped;

    assign word     = i_paddr[APB_ADDR_W-1:2];
    assign unmapped = (word / COEFF_SLOTS >= NUM_FILTERS) || (word % COEFF_SLOTS > BIAS_SLOT);

    // Valid pipeline is clear one edge into reset
    a_res_valid_reset: assert property (@(posedge i_clk) i_rst |=> !i_res_valid)
        else begin
            $error("o_res_valid high during reset");
            assert_fails++;
        end

    // Slave error only in an access phase, and there for every unmapped word
    a_pslverr_access: assert property (
        @(posedge i_clk) disable iff (i_rst) i_pslverr == (i_psel && i_penable && unmapped))
        else begin
            $error("o_pslverr does not match the access phase and the address map");
            assert_fails++;
        end

    // Result valid trails the window valid by the MAC pipeline depth
    a_res_valid_latency: assert property (
        @(posedge i_clk) disable iff (i_rst) i_res_valid == $past(i_win_valid, MAC_LATENCY))
        else begin
            $error("o_res_valid does not follow the window valid by %0d cycles", MAC_LATENCY);
            assert_fails++;
        end

endmodule

// Attach to every conv_top instance
bind conv_top conv_assertions assertions_inst (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_paddr     (i_paddr),
    .i_pslverr   (o_pslverr),
    .i_win_valid (win_valid),
    .i_res_valid (o_res_valid)
);

// ==== tb/conv_tb.sv ====
`timescale 1ns/1ps

module conv_tb import conv_pkg::*; ();

    localparam int FRAME_PIX     = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int OUT_W         = FRAME_WIDTH - KERNEL_SIZE + 1;
    localparam int OUT_PER_FRAME = OUT_W * (FRAME_HEIGHT - KERNEL_SIZE + 1);
    localparam int RST_TIMEOUT   = 100;
    localparam int APB_TIMEOUT   = 16;
    localparam int RES_TIMEOUT   = 2000;

    // Kernel kinds and pixel patterns
    localparam int K_IDENT = 0;
    localparam int K_BIAS  = 1;
    localparam int K_NEG   = 2;
    localparam int K_RAND  = 3;
    localparam int P_RAMP  = 0;
    localparam int P_CONST = 1;
    localparam int P_RAND  = 2;

    //////////////////////////////
    // Test table
    //////////////////////////////

    localparam int NUM_ROWS = 5;
    localparam int TBL_KERNEL [NUM_ROWS] = '{K_IDENT, K_BIAS, K_NEG, K_RAND, K_RAND};
    localparam int TBL_PIXELS [NUM_ROWS] = '{P_RAMP, P_RAND, P_CONST, P_RAND, P_RAND};
    // Gap chance in percent before each pixel
    localparam int TBL_GAP    [NUM_ROWS] = '{0, 0, 0, 0, 30};
    localparam int TBL_BIAS   [NUM_ROWS] = '{0, 1234, -77, 100, -5};
    // Last row streams two frames back to back
    localparam int TBL_FRAMES [NUM_ROWS] = '{1, 1, 1, 1, 2};
    string row_name [NUM_ROWS] = '{"identity ramp", "bias-only", "negative constant",
                                   "random", "random gaps two frames"};

    logic                                 clk;
    logic                                 rst;
    logic                                 psel;
    logic                                 penable;
    logic                                 pwrite;
    logic [APB_ADDR_W-1:0]                paddr;
    logic [APB_DATA_W-1:0]                pwdata;
    logic                                 pready;
    logic [APB_DATA_W-1:0]                prdata;
    logic                                 pslverr;
    logic                                 pix_valid;
    logic [PIXEL_W-1:0]                   pix;
    logic                                 res_valid;
    logic [NUM_FILTERS-1:0][RESULT_W-1:0] results;

    // Reference copies of the stimulus
    logic [PIXEL_W-1:0] frame_pix [2*FRAME_PIX];
    int                 weight_m  [NUM_FILTERS][KERNEL_TAPS];
    int                 bias_m    [NUM_FILTERS];

    int errors;
    int checks;
    int tests;
    bit timed_out;

    conv_clk_gen clk_gen_inst (
        .o_clk (clk),
        .o_rst (rst)
    );

    conv_top conv_top_inst (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_psel      (psel),
        .i_penable   (penable),
        .i_pwrite    (pwrite),
        .i_paddr     (paddr),
        .i_pwdata    (pwdata),
        .o_pready    (pready),
        .o_prdata    (prdata),
        .o_pslverr   (pslverr),
        .i_pix_valid (pix_valid),
        .i_pix       (pix),
        .o_res_valid (res_valid),
        .o_results   (results)
    );

    task automatic check_value(input string what, input logic signed [63:0] actual,
                               input logic signed [63:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("Fail at %0t: %s: got %0d, expected %0d", $time, what, actual, expected);
            errors++;
        end
    endtask

    //////////////////////////////
    // APB master
    //////////////////////////////

    task automatic apb_access(input bit write, input int filt, input int slot,
                              input logic [APB_DATA_W-1:0] wdata,
                              output logic [APB_DATA_W-1:0] rdata, output logic err);
        int waited;
        // Setup phase
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= APB_ADDR_W'((filt * COEFF_SLOTS + slot) * 4);
        pwdata  <= wdata;
        // Access phase, sampled mid-cycle
        @(posedge clk);
        penable <= 1'b1;
        for (waited = 0; waited < APB_TIMEOUT; waited++) begin
            @(negedge clk);
            if (pready) break;
        end
        if (!pready) begin
            $display("APB access to filter %0d slot %0d got no pready", filt, slot);
            timed_out = 1'b1;
        end else begin
            // Zero wait states, pready in the first access cycle
            check_value("APB wait cycles", waited, 0);
        end
        rdata = prdata;
        err   = pslverr;
        // Write lands on this edge
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic coeff_access_test();
        logic [APB_DATA_W-1:0] rd;
        logic                  err;
        apb_access(1'b1, 2, 3, 32'h0000_8123, rd, err);
        check_value("weight write pslverr", err, 0);
        // Upper bus bits are dropped
        apb_access(1'b1, 5, BIAS_SLOT, 32'hFFFF_7ABC, rd, err);
        apb_access(1'b0, 2, 3, '0, rd, err);
        check_value("weight read", rd, 32'hFFFF_8123);
        check_value("weight read pslverr", err, 0);
        apb_access(1'b0, 5, BIAS_SLOT, '0, rd, err);
        check_value("bias read", rd, 32'h0000_7ABC);
        // Unmapped slot and filter
        apb_access(1'b1, 2, 26, 32'h0000_5555, rd, err);
        check_value("slot 26 write pslverr", err, 1);
        apb_access(1'b0, 2, 26, '0, rd, err);
        check_value("slot 26 read data", rd, 0);
        check_value("slot 26 read pslverr", err, 1);
        apb_access(1'b1, 6, 3, 32'h0000_1111, rd, err);
        check_value("filter 6 write pslverr", err, 1);
        apb_access(1'b0, 6, 3, '0, rd, err);
        check_value("filter 6 read data", rd, 0);
        check_value("filter 6 read pslverr", err, 1);
        // Stored values survive the errored writes
        apb_access(1'b0, 2, 3, '0, rd, err);
        check_value("weight after errored writes", rd, 32'hFFFF_8123);
        apb_access(1'b0, 5, BIAS_SLOT, '0, rd, err);
        check_value("bias after errored writes", rd, 32'h0000_7ABC);
    endtask

    task automatic program_coeffs(input int row);
        logic [APB_DATA_W-1:0]     rd;
        logic                      err;
        logic signed [COEFF_W-1:0] rnd;
        for (int f = 0; f < NUM_FILTERS; f++) begin
            for (int t = 0; t < KERNEL_TAPS; t++) begin
                rnd = COEFF_W'($urandom);
                case (TBL_KERNEL[row])
                    K_IDENT: weight_m[f][t] = (t == KERNEL_TAPS / 2) ? 1 : 0;
                    K_NEG:   weight_m[f][t] = -1;
                    K_RAND:  weight_m[f][t] = rnd;
                    default: weight_m[f][t] = 0;
                endcase
                apb_access(1'b1, f, t, APB_DATA_W'(weight_m[f][t]), rd, err);
            end
            bias_m[f] = TBL_BIAS[row] + ((TBL_KERNEL[row] == K_RAND) ? f * 111 : 0);
            apb_access(1'b1, f, BIAS_SLOT, APB_DATA_W'(bias_m[f]), rd, err);
        end
    endtask

    task automatic make_frames(input int row);
        for (int p = 0; p < TBL_FRAMES[row] * FRAME_PIX; p++) begin
            case (TBL_PIXELS[row])
                P_RAMP:  frame_pix[p] = PIXEL_W'(p);
                P_CONST: frame_pix[p] = 8'd200;
                default: frame_pix[p] = PIXEL_W'($urandom);
            endcase
        end
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Window sum of pixel times weight plus bias, row 0 on top
    function automatic longint expected_result(input int f, input int idx);
        int     frame;
        int     pos;
        int     top;
        int     left;
        longint sum;
        frame = idx / OUT_PER_FRAME;
        pos   = idx % OUT_PER_FRAME;
        top   = pos / OUT_W;
        left  = pos % OUT_W;
        sum   = bias_m[f];
        for (int i = 0; i < KERNEL_SIZE; i++) begin
            for (int j = 0; j < KERNEL_SIZE; j++) begin
                sum += longint'(frame_pix[frame*FRAME_PIX + (top+i)*FRAME_WIDTH + left + j])
                       * weight_m[f][i*KERNEL_SIZE + j];
            end
        end
        return sum;
    endfunction

    task automatic drive_frames(input int row);
        int idle;
        for (int p = 0; p < TBL_FRAMES[row] * FRAME_PIX; p++) begin
            // Random idle cycles ahead of a pixel
            idle = ($urandom_range(99) < TBL_GAP[row]) ? $urandom_range(3, 1) : 0;
            repeat (idle) begin
                @(posedge clk);
                pix_valid <= 1'b0;
            end
            @(posedge clk);
            pix_valid <= 1'b1;
            pix       <= frame_pix[p];
        end
        @(posedge clk);
        pix_valid <= 1'b0;
    endtask

    task automatic collect_results(input int row);
        int                         expected_count;
        int                         got;
        int                         extra;
        logic signed [RESULT_W-1:0] res;
        expected_count = TBL_FRAMES[row] * OUT_PER_FRAME;
        got = 0;
        while (got < expected_count && !timed_out) begin
            for (int waited = 0; waited < RES_TIMEOUT; waited++) begin
                @(negedge clk);
                if (res_valid) break;
            end
            if (!res_valid) begin
                $display("Result %0d of test %0d never arrived", got, tests + 1);
                timed_out = 1'b1;
            end else begin
                for (int f = 0; f < NUM_FILTERS; f++) begin
                    res = results[f];
                    check_value($sformatf("filter %0d result %0d", f, got), res,
                                expected_result(f, got));
                end
                got++;
            end
        end
        // Nothing more may follow the last window
        extra = 0;
        repeat (4 * MAC_LATENCY) begin
            @(negedge clk);
            if (res_valid) extra++;
        end
        check_value("result count", got + extra, expected_count);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int row_errors;
        int assert_errors;
        void'($urandom(18936));
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        pix_valid = 1'b0;
        pix       = '0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        timed_out = 1'b0;

        for (int i = 0; i < RST_TIMEOUT; i++) begin
            @(negedge clk);
            if (!rst) break;
        end
        if (rst) begin
            $display("Reset was never released");
            timed_out = 1'b1;
        end

        if (!timed_out) begin
            row_errors = errors;
            coeff_access_test();
            tests++;
            $display("Test %0d coefficient access: %0d mismatches", tests, errors - row_errors);
        end

        for (int row = 0; row < NUM_ROWS && !timed_out; row++) begin
            row_errors = errors;
            program_coeffs(row);
            make_frames(row);
            fork
                drive_frames(row);
                collect_results(row);
            join
            tests++;
            $display("Test %0d %s: %0d mismatches", tests, row_name[row], errors - row_errors);
        end

        assert_errors = conv_top_inst.assertions_inst.assert_fails;
        $display("Tests %0d, checks %0d, mismatches %0d, assertion failures %0d",
                 tests, checks, errors, assert_errors);
        if (errors == 0 && assert_errors == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
logic/conv_pkg.sv
logic/conv_coeff_regs.sv
logic/conv_line_buffer.sv
logic/conv_filter_mac.sv
logic/conv_top.sv
tb/conv_clk_gen.sv
tb/conv_assertions.sv
tb/conv_tb.sv
